/* flist.f */
+incdir+include
logic/perf_mon_pkg.sv
logic/stall_classifier.sv
logic/perf_counter_bank.sv
logic/axil_slave_fsm.sv
logic/perf_csr_file.sv
logic/perf_mon_top.sv
dv/perf_mon_assertions.sv
dv/perf_mon_tb.sv

/* Bender.yml */
package:
  name: perf_mon

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/perf_mon_pkg.sv
      - logic/stall_classifier.sv
      - logic/perf_counter_bank.sv
      - logic/axil_slave_fsm.sv
      - logic/perf_csr_file.sv
      - logic/perf_mon_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/perf_mon_assertions.sv
      - dv/perf_mon_tb.sv

/* dv/perf_mon_tb.sv */
`default_nettype none

`include "perf_mon_settings.svh"

module perf_mon_tb;

  import perf_mon_pkg::*;

  localparam int TIMEOUT_CYCLES = 32;

  logic         clk_i;
  logic         rst_n_i;
  core_events_s ev;
  axil_req_s    req;
  axil_rsp_s    rsp;

  cnt_t        model_cnt [`PERF_NUM_CNT];
  logic        frz_seen; // model of the registered freeze flag
  logic        clear_due;
  logic        ctrl_hs; // clearing write handshakes on the coming edge
  logic        clr_now;
  cnt_inc_t    incs;

  perf_mon_top u_perf_mon_top (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .events_i   (ev),
    .axil_req_i (req),
    .axil_rsp_o (rsp)
  );

  bind perf_mon_top perf_mon_assertions u_perf_mon_assertions (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_i (axil_rsp_o)
  );

  always
  begin
    #50 clk_i = ~clk_i;
  end

  function automatic cnt_inc_t expected_incs(input core_events_s e);
    cnt_inc_t v;
    logic     dmem_hit;
    v = '0;
    dmem_hit = e.dmem_wait && e.dmem_en;
    if (!e.freeze)
    begin
      v[`PERF_CNT_CYCLES]    = 1'b1;
      v[`PERF_CNT_IMEM]      = e.imem_wait;
      v[`PERF_CNT_DMEM]      = dmem_hit;
      v[`PERF_CNT_RSRV]      = !dmem_hit && e.rsrv_stall;
      v[`PERF_CNT_DX]        = !dmem_hit && !e.rsrv_stall && e.dx_stall;
      v[`PERF_CNT_REDIRECT]  = !dmem_hit && !e.rsrv_stall && !e.dx_stall && e.redirect;
      v[`PERF_CNT_CGNI_FULL] = !e.in_ready;
      v[`PERF_CNT_CGNO_FULL] = !e.out_ready;
    end
    return v;
  endfunction

  // reference counters stepped on the DUT's edges
  always @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `PERF_NUM_CNT; i++)
        model_cnt[i] = '0;
      frz_seen  = 1'b1;
      clear_due = 1'b0;
    end
    else
    begin
      clr_now   = (frz_seen && !ev.freeze) || clear_due;
      clear_due = ctrl_hs; // soft clear lands one edge later
      ctrl_hs   = 1'b0;
      incs      = expected_incs(ev);
      frz_seen  = ev.freeze;
      for (int i = 0; i < `PERF_NUM_CNT; i++)
      begin
        if (clr_now)
          model_cnt[i] = '0;
        else if (incs[i])
          model_cnt[i] = model_cnt[i] + cnt_t'(1);
      end
    end
  end

  always @(u_perf_mon_top.u_perf_mon_assertions.fail_count)
  begin
    if (u_perf_mon_top.u_perf_mon_assertions.fail_count != 0)
    begin
      $display("a bound protocol assertion failed at time %0t", $time);
      $display("ERRORS FOUND");
      $fatal(1, "stopping on assertion failure");
    end
  end

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at time %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopping on first mismatch");
  endtask

  task automatic timed_out(input string what);
    $display("timeout at time %0t: %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "stopping on timeout");
  endtask

  // starts and ends on a falling edge
  task automatic run_cycles(input int n, input logic frz);
    logic [$bits(core_events_s)-1:0] bits;
    for (int c = 0; c < n; c++)
    begin
      bits = $bits(core_events_s)'($urandom);
      ev = core_events_s'(bits);
      ev.freeze = frz;
      @(negedge clk_i);
    end
  endtask

  task automatic check_read(input axil_addr_t addr);
    int         n;
    axil_data_t exp_data;
    axil_resp_t exp_resp;
    req.arvalid = 1'b1;
    req.araddr  = addr;
    n = 0;
    while (!rsp.arready)
    begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT_CYCLES)
        timed_out("ARREADY never rose");
    end
    // model already holds the value seen at the coming AR handshake
    exp_data = '0;
    exp_resp = `PERF_RESP_OKAY;
    if (addr < 8'(`PERF_NUM_CNT * 4) && addr[1:0] == 2'b00)
      exp_data = model_cnt[addr[4:2]];
    else if (addr == `PERF_ADDR_STATUS)
      exp_data = axil_data_t'(frz_seen);
    else
      exp_resp = `PERF_RESP_SLVERR;
    @(negedge clk_i);
    req.arvalid = 1'b0;
    repeat ($urandom_range(0, 6)) @(negedge clk_i); // back-pressure
    req.rready = 1'b1;
    n = 0;
    while (!rsp.rvalid)
    begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT_CYCLES)
        timed_out("RVALID never rose");
    end
    assert (rsp.rdata == exp_data && rsp.rresp == exp_resp)
    else report_mismatch($sformatf("read 0x%02h got %0h resp %0d, expected %0h resp %0d",
                                   addr, rsp.rdata, rsp.rresp, exp_data, exp_resp));
    @(negedge clk_i);
    req.rready = 1'b0;
  endtask

  task automatic check_write(input axil_addr_t addr, input axil_data_t data);
    int         n;
    axil_resp_t exp_resp;
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = '1;
    n = 0;
    while (!(rsp.awready && rsp.wready))
    begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT_CYCLES)
        timed_out("AWREADY and WREADY never rose");
    end
    exp_resp = (addr == `PERF_ADDR_CTRL) ? `PERF_RESP_OKAY : `PERF_RESP_SLVERR;
    if (addr == `PERF_ADDR_CTRL && data[0])
      ctrl_hs = 1'b1;
    @(negedge clk_i);
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    repeat ($urandom_range(0, 6)) @(negedge clk_i);
    req.bready = 1'b1;
    n = 0;
    while (!rsp.bvalid)
    begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT_CYCLES)
        timed_out("BVALID never rose");
    end
    assert (rsp.bresp == exp_resp)
    else report_mismatch($sformatf("write 0x%02h got resp %0d, expected %0d",
                                   addr, rsp.bresp, exp_resp));
    @(negedge clk_i);
    req.bready = 1'b0;
  endtask

  task automatic read_all_counters();
    for (int i = 0; i < `PERF_NUM_CNT; i++)
      check_read(axil_addr_t'(4 * i));
    check_read(`PERF_ADDR_STATUS);
  endtask

  initial
  begin
    void'($urandom(32'h4e106c9d));
    clk_i    = 1'b0;
    rst_n_i  = 1'b0;
    ctrl_hs  = 1'b0;
    req      = '0;
    ev       = '0;
    ev.freeze    = 1'b1;
    ev.in_ready  = 1'b1;
    ev.out_ready = 1'b1;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;

    read_all_counters(); // still frozen so all zero
    for (int b = 0; b < 3; b++)
    begin
      run_cycles(100, 1'b0);
      read_all_counters();
    end

    for (int r = 0; r < 4; r++)
    begin
      run_cycles($urandom_range(5, 40), 1'b1);
      read_all_counters();
      run_cycles($urandom_range(10, 50), 1'b0);
      read_all_counters();
    end

    // register map and soft clear
    run_cycles(3, 1'b1);
    check_write(`PERF_ADDR_CTRL, 32'h1);
    read_all_counters();
    run_cycles(1, 1'b0);
    run_cycles(40, 1'b0);
    check_write(8'h08, 32'hffff_ffff);
    read_all_counters();
    check_write(`PERF_ADDR_CTRL, 32'h0);
    check_write(`PERF_ADDR_CTRL, 32'h1); // clear while counting
    read_all_counters();
    check_read(8'h30);
    run_cycles(20, 1'b0);
    read_all_counters();

    if (u_perf_mon_top.u_perf_mon_assertions.fail_count == 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
    begin
      $display("ERRORS FOUND");
      $fatal(1, "bound assertions failed");
    end
  end

endmodule

`default_nettype wire

/* dv/perf_mon_assertions.sv */
`default_nettype none

`include "perf_mon_settings.svh"

module perf_mon_assertions
  (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  perf_mon_pkg::axil_req_s axil_req_i,
    input  perf_mon_pkg::axil_rsp_s axil_rsp_i
  );

  import perf_mon_pkg::*;

  int unsigned fail_count = 0; // watched by the testbench

  // quiet bus while held in reset
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !axil_rsp_i.bvalid && !axil_rsp_i.rvalid && !axil_rsp_i.arready
                 && !axil_rsp_i.awready && !axil_rsp_i.wready)
  else
  begin
    $error("response or ready high during reset");
    fail_count++;
  end

  // first cycle out of reset
  reset_exit: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !axil_rsp_i.bvalid && !axil_rsp_i.rvalid)
  else
  begin
    $error("response valid in the first cycle after reset");
    fail_count++;
  end

  read_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.rvalid && !axil_req_i.rready |=>
      axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata) && $stable(axil_rsp_i.rresp))
  else
  begin
    $error("read response dropped or changed before RREADY");
    fail_count++;
  end

  read_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.rvalid |-> !axil_rsp_i.arready)
  else
  begin
    $error("ARREADY high while a read response is pending");
    fail_count++;
  end

  write_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=>
      axil_rsp_i.bvalid && $stable(axil_rsp_i.bresp))
  else
  begin
    $error("write response dropped or changed before BREADY");
    fail_count++;
  end

  write_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.bvalid |-> !axil_rsp_i.awready && !axil_rsp_i.wready && !axil_rsp_i.arready)
  else
  begin
    $error("new transaction accepted while a write response is pending");
    fail_count++;
  end

endmodule

`default_nettype wire

/* logic/perf_mon_top.sv */
`default_nettype none

module perf_mon_top
  (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  perf_mon_pkg::core_events_s events_i,
    input  perf_mon_pkg::axil_req_s    axil_req_i,
    output perf_mon_pkg::axil_rsp_s    axil_rsp_o
  );

  import perf_mon_pkg::*;

  cnt_inc_t   inc;
  logic       clear;
  logic       frozen;
  logic       soft_clear;
  cnt_array_t counts;
  logic       wr_en;
  axil_addr_t wr_addr;
  axil_data_t wr_data;
  axil_resp_t wr_resp;
  logic       rd_en;
  axil_addr_t rd_addr;
  axil_data_t rd_data;
  axil_resp_t rd_resp;

  stall_classifier u_stall_classifier (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .events_i     (events_i),
    .soft_clear_i (soft_clear),
    .inc_o        (inc),
    .clear_o      (clear),
    .frozen_o     (frozen)
  );

  perf_counter_bank u_perf_counter_bank (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .inc_i    (inc),
    .clear_i  (clear),
    .counts_o (counts)
  );

  axil_slave_fsm u_axil_slave_fsm (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (axil_req_i),
    .rsp_o     (axil_rsp_o),
    .wr_en_o   (wr_en),
    .wr_addr_o (wr_addr),
    .wr_data_o (wr_data),
    .wr_resp_i (wr_resp),
    .rd_en_o   (rd_en),
    .rd_addr_o (rd_addr),
    .rd_data_i (rd_data),
    .rd_resp_i (rd_resp)
  );

  perf_csr_file u_perf_csr_file (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wr_en_i      (wr_en),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .wr_resp_o    (wr_resp),
    .rd_en_i      (rd_en),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data),
    .rd_resp_o    (rd_resp),
    .counts_i     (counts),
    .frozen_i     (frozen),
    .soft_clear_o (soft_clear)
  );

endmodule

`default_nettype wire

/* logic/perf_csr_file.sv */
`default_nettype none

`include "perf_mon_settings.svh"

module perf_csr_file
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     wr_en_i,
    input  perf_mon_pkg::axil_addr_t wr_addr_i,
    input  perf_mon_pkg::axil_data_t wr_data_i,
    output perf_mon_pkg::axil_resp_t wr_resp_o,
    input  logic                     rd_en_i,
    input  perf_mon_pkg::axil_addr_t rd_addr_i,
    output perf_mon_pkg::axil_data_t rd_data_o,
    output perf_mon_pkg::axil_resp_t rd_resp_o,
    input  perf_mon_pkg::cnt_array_t counts_i,
    input  logic                     frozen_i,
    output logic                     soft_clear_o
  );

  import perf_mon_pkg::*;

  cnt_idx_t rd_idx;
  logic     rd_is_cnt;
  logic     rd_is_status;
  logic     wr_is_ctrl;
  logic     soft_clear_q;

  assign rd_idx       = rd_addr_i[2 +: $bits(cnt_idx_t)];
  assign rd_is_cnt    = (rd_addr_i < axil_addr_t'(`PERF_NUM_CNT * 4))
                        && (rd_addr_i[1:0] == 2'b00); // word aligned only
  assign rd_is_status = (rd_addr_i == `PERF_ADDR_STATUS);
  assign wr_is_ctrl   = (wr_addr_i == `PERF_ADDR_CTRL);

  always_comb
  begin
    rd_data_o = '0;
    rd_resp_o = `PERF_RESP_OKAY;
    if (rd_en_i)
    begin
      if (rd_is_cnt)
      begin
        rd_data_o = counts_i[rd_idx];
      end
      else if (rd_is_status)
      begin
        rd_data_o = axil_data_t'(frozen_i);
      end
      else
      begin
        rd_resp_o = `PERF_RESP_SLVERR;
      end
    end
  end

  // counters are read only, ctrl is the only writable word
  assign wr_resp_o = wr_is_ctrl ? `PERF_RESP_OKAY : `PERF_RESP_SLVERR;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      soft_clear_q <= 1'b0;
    end
    else
    begin
      soft_clear_q <= wr_en_i & wr_is_ctrl & wr_data_i[0]; // one cycle pulse
    end
  end

  assign soft_clear_o = soft_clear_q;

endmodule

`default_nettype wire

/* logic/axil_slave_fsm.sv */
`default_nettype none

`include "perf_mon_settings.svh"

module axil_slave_fsm
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  perf_mon_pkg::axil_req_s  req_i,
    output perf_mon_pkg::axil_rsp_s  rsp_o,
    output logic                     wr_en_o,
    output perf_mon_pkg::axil_addr_t wr_addr_o,
    output perf_mon_pkg::axil_data_t wr_data_o,
    input  perf_mon_pkg::axil_resp_t wr_resp_i,
    output logic                     rd_en_o,
    output perf_mon_pkg::axil_addr_t rd_addr_o,
    input  perf_mon_pkg::axil_data_t rd_data_i,
    input  perf_mon_pkg::axil_resp_t rd_resp_i
  );

  import perf_mon_pkg::*;

  axil_state_e state_q;
  logic        wr_ready_q; // drives awready and wready together
  logic        rd_ready_q;
  axil_resp_t  bresp_q;
  axil_data_t  rdata_q;
  axil_resp_t  rresp_q;
  axil_data_t  strb_mask;

  // handshake edges
  assign rd_en_o = rd_ready_q & req_i.arvalid;
  assign wr_en_o = wr_ready_q & req_i.awvalid & req_i.wvalid;

  assign rd_addr_o = req_i.araddr;
  assign wr_addr_o = req_i.awaddr;

  always_comb
  begin
    for (int b = 0; b < `PERF_DATA_W/8; b++)
    begin
      strb_mask[8*b +: 8] = {8{req_i.wstrb[b]}};
    end
  end

  assign wr_data_o = req_i.wdata & strb_mask; // unstrobed bytes read as 0

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q    <= IDLE;
      wr_ready_q <= 1'b0;
      rd_ready_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (rd_en_o)
          begin
            state_q    <= READ_RESP;
            rd_ready_q <= 1'b0;
          end
          else if (wr_en_o)
          begin
            state_q    <= WRITE_RESP;
            wr_ready_q <= 1'b0;
          end
          else
          begin
            // read wins when both are requested
            rd_ready_q <= req_i.arvalid;
            wr_ready_q <= req_i.awvalid & req_i.wvalid & ~req_i.arvalid;
          end
        end
        WRITE_RESP:
        begin
          if (req_i.bready)
            state_q <= IDLE;
        end
        READ_RESP:
        begin
          if (req_i.rready)
            state_q <= IDLE;
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_en_o)
    begin
      rdata_q <= rd_data_i;
      rresp_q <= rd_resp_i;
    end
    if (wr_en_o)
      bresp_q <= wr_resp_i;
  end

  always_comb
  begin
    rsp_o.awready = wr_ready_q;
    rsp_o.wready  = wr_ready_q;
    rsp_o.bvalid  = (state_q == WRITE_RESP);
    rsp_o.bresp   = bresp_q;
    rsp_o.arready = rd_ready_q;
    rsp_o.rvalid  = (state_q == READ_RESP);
    rsp_o.rdata   = rdata_q;
    rsp_o.rresp   = rresp_q;
  end

endmodule

`default_nettype wire

/* logic/perf_counter_bank.sv */
`default_nettype none

`include "perf_mon_settings.svh"

module perf_counter_bank
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  perf_mon_pkg::cnt_inc_t   inc_i,
    input  logic                     clear_i,
    output perf_mon_pkg::cnt_array_t counts_o
  );

  import perf_mon_pkg::*;

  cnt_array_t cnt_q;

  // wrapping counters, clear beats increment
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q <= '0;
    end
    else if (clear_i)
    begin
      cnt_q <= '0;
    end
    else
    begin
      for (int i = 0; i < `PERF_NUM_CNT; i++)
      begin
        if (inc_i[i])
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
      end
    end
  end

  assign counts_o = cnt_q;

endmodule

`default_nettype wire

/* logic/stall_classifier.sv */
`default_nettype none

`include "perf_mon_settings.svh"

module stall_classifier
  (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  perf_mon_pkg::core_events_s events_i,
    input  logic                       soft_clear_i,
    output perf_mon_pkg::cnt_inc_t     inc_o,
    output logic                       clear_o,
    output logic                       frozen_o
  );

  import perf_mon_pkg::*;

  logic freeze_r;
  logic unfreeze;

  // starts frozen so the first release also clears
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      freeze_r <= 1'b1;
    end
    else
    begin
      freeze_r <= events_i.freeze;
    end
  end

  assign unfreeze = freeze_r & ~events_i.freeze; // tile leaving freeze
  assign clear_o  = unfreeze | soft_clear_i;
  assign frozen_o = freeze_r;

  always_comb
  begin
    inc_o = '0;
    if (!events_i.freeze)
    begin
      inc_o[`PERF_CNT_CYCLES] = 1'b1;
      inc_o[`PERF_CNT_IMEM]   = events_i.imem_wait;
      // one cause per cycle, dmem first
      if (events_i.dmem_wait & events_i.dmem_en)
        inc_o[`PERF_CNT_DMEM] = 1'b1;
      else if (events_i.rsrv_stall)
        inc_o[`PERF_CNT_RSRV] = 1'b1;
      else if (events_i.dx_stall)
        inc_o[`PERF_CNT_DX] = 1'b1;
      else if (events_i.redirect)
        inc_o[`PERF_CNT_REDIRECT] = 1'b1;
      inc_o[`PERF_CNT_CGNI_FULL] = ~events_i.in_ready;
      inc_o[`PERF_CNT_CGNO_FULL] = ~events_i.out_ready;
    end
  end

endmodule

`default_nettype wire

/* logic/perf_mon_pkg.sv */
`default_nettype none

`include "perf_mon_settings.svh"

package perf_mon_pkg;

  typedef logic [`PERF_DATA_W-1:0] cnt_t;
  typedef logic [$clog2(`PERF_NUM_CNT)-1:0] cnt_idx_t;
  typedef logic [`PERF_ADDR_W-1:0] axil_addr_t;
  typedef logic [`PERF_DATA_W-1:0] axil_data_t;
  typedef logic [1:0] axil_resp_t;
  typedef logic [`PERF_NUM_CNT-1:0] cnt_inc_t; // one bit per counter slot
  typedef cnt_t [`PERF_NUM_CNT-1:0] cnt_array_t;

  // status sampled from the core every cycle
  typedef struct packed {
    logic freeze;
    logic imem_wait;
    logic dmem_wait;
    logic dmem_en;
    logic rsrv_stall; // lr.w.acquire wait
    logic dx_stall; // bypass and load use
    logic redirect; // branch taken penalty
    logic in_ready; // proc input buffer accepting
    logic out_ready; // output buffer accepting
  } core_events_s;

  typedef struct packed {
    logic                      awvalid;
    axil_addr_t                awaddr;
    logic                      wvalid;
    axil_data_t                wdata;
    logic [`PERF_DATA_W/8-1:0] wstrb;
    logic                      bready;
    logic                      arvalid;
    axil_addr_t                araddr;
    logic                      rready;
  } axil_req_s;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_s;

  typedef enum logic [1:0] {IDLE, WRITE_RESP, READ_RESP} axil_state_e;

endpackage

`default_nettype wire

/* include/perf_mon_settings.svh */
`ifndef PERF_MON_SETTINGS_SVH
`define PERF_MON_SETTINGS_SVH

`define PERF_DATA_W 32 // bus and counter width
`define PERF_ADDR_W 8
`define PERF_NUM_CNT 8

// byte addresses, counter i sits at 4*i
`define PERF_ADDR_STATUS 8'h20 // bit 0 current freeze
`define PERF_ADDR_CTRL 8'h24 // bit 0 written as 1 clears counters

`define PERF_RESP_OKAY 2'b00
`define PERF_RESP_SLVERR 2'b10

// counter slots
`define PERF_CNT_CYCLES 0
`define PERF_CNT_DMEM 1
`define PERF_CNT_IMEM 2
`define PERF_CNT_DX 3
`define PERF_CNT_REDIRECT 4
`define PERF_CNT_RSRV 5
`define PERF_CNT_CGNI_FULL 6
`define PERF_CNT_CGNO_FULL 7

`endif
